// File: source/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int INST_W     = 32;
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int MASK_W     = XLEN / 8;  // one bit per byte lane

    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam logic [INST_W-1:0] EBREAK_WORD = 32'h0010_0073;

    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_BRANCH    = 7'b1100011,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    typedef enum logic [5:0] {
        KIND_NONE,
        KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_SLT, KIND_SLTU,
        KIND_ADDI, KIND_ANDI, KIND_XORI, KIND_SLTIU, KIND_SLLI, KIND_SRAI,
        KIND_ADDW, KIND_SLLW, KIND_ADDIW,
        KIND_LW, KIND_LD, KIND_LBU, KIND_LH,
        KIND_SB, KIND_SH, KIND_SW, KIND_SD,
        KIND_JAL, KIND_JALR, KIND_LUI, KIND_AUIPC,
        KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU
    } inst_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRA,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG,      // rs1 op rs2
        SRC_IMM,      // rs1 op imm
        SRC_IMM_PC,   // pc + imm
        SRC_PC_FOUR   // pc + 4, link value
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT
    } imm_sel_e;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD,
        MEM_DOUBLE
    } mem_size_e;

endpackage

// File: source/op_class.sv
`timescale 1ns/1ps

module op_class import rv_decode_pkg::*; (
    input  logic [INST_W-1:0] inst,
    output inst_kind_e        kind,
    output imm_sel_e          imm_sel,
    output logic              illegal
);

    opcode_e             opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;

    assign opcode = opcode_e'(inst[OPCODE_W-1:0]);
    assign funct3 = inst[FUNCT3_LSB +: FUNCT3_W];
    assign funct7 = inst[FUNCT7_LSB +: FUNCT7_W];

    always_comb begin
        kind    = KIND_NONE;
        imm_sel = IMM_I;
        case (opcode)
            OPC_OP: begin
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0000000) begin
                            kind = KIND_ADD;
                        end else if (funct7 == 7'b0100000) begin
                            kind = KIND_SUB;
                        end
                    end
                    3'b111: if (funct7 == 7'b0) kind = KIND_AND;  // funct7 01 is remu
                    3'b110: if (funct7 == 7'b0) kind = KIND_OR;
                    3'b010: if (funct7 == 7'b0) kind = KIND_SLT;
                    3'b011: if (funct7 == 7'b0) kind = KIND_SLTU;
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: kind = KIND_ADDI;
                    3'b111: kind = KIND_ANDI;
                    3'b100: kind = KIND_XORI;
                    3'b011: kind = KIND_SLTIU;
                    3'b001: begin
                        imm_sel = IMM_SHAMT;
                        if (funct7[6:1] == 6'b000000) kind = KIND_SLLI;  // bit 25 is shamt[5]
                    end
                    3'b101: begin
                        imm_sel = IMM_SHAMT;
                        if (funct7[6:1] == 6'b010000) kind = KIND_SRAI;
                    end
                    default: ;
                endcase
            end
            OPC_OP_32: begin
                if (funct7 == 7'b0) begin  // mulw/divw/remw carry funct7 01
                    case (funct3)
                        3'b000:  kind = KIND_ADDW;
                        3'b001:  kind = KIND_SLLW;
                        default: ;
                    endcase
                end
            end
            OPC_OP_IMM_32: begin
                if (funct3 == 3'b000) kind = KIND_ADDIW;
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b010:  kind = KIND_LW;
                    3'b011:  kind = KIND_LD;
                    3'b100:  kind = KIND_LBU;
                    3'b001:  kind = KIND_LH;
                    default: ;
                endcase
            end
            OPC_STORE: begin
                imm_sel = IMM_S;
                case (funct3)
                    3'b000:  kind = KIND_SB;
                    3'b001:  kind = KIND_SH;
                    3'b010:  kind = KIND_SW;
                    3'b011:  kind = KIND_SD;
                    default: ;
                endcase
            end
            OPC_JAL: begin
                imm_sel = IMM_J;
                kind    = KIND_JAL;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) kind = KIND_JALR;
            end
            OPC_LUI: begin
                imm_sel = IMM_U;
                kind    = KIND_LUI;
            end
            OPC_AUIPC: begin
                imm_sel = IMM_U;
                kind    = KIND_AUIPC;
            end
            OPC_BRANCH: begin
                imm_sel = IMM_B;
                case (funct3)
                    3'b000:  kind = KIND_BEQ;
                    3'b001:  kind = KIND_BNE;
                    3'b100:  kind = KIND_BLT;
                    3'b101:  kind = KIND_BGE;
                    3'b110:  kind = KIND_BLTU;
                    3'b111:  kind = KIND_BGEU;
                    default: ;
                endcase
            end
            OPC_SYSTEM: ;  // only ebreak, caught below
            default: ;
        endcase
    end

    assign illegal = (kind == KIND_NONE) && (inst != EBREAK_WORD);

endmodule

// File: source/alu_ctrl.sv
`timescale 1ns/1ps

module alu_ctrl import rv_decode_pkg::*; (
    input  inst_kind_e kind,
    output alu_op_e    alu_op,
    output alu_src_e   alu_src,
    output logic       word_op
);

    always_comb begin
        alu_op  = ALU_ADD;
        alu_src = SRC_REG;
        word_op = 1'b0;
        case (kind)
            KIND_ADD:   alu_op = ALU_ADD;
            KIND_SUB:   alu_op = ALU_SUB;
            KIND_AND:   alu_op = ALU_AND;
            KIND_OR:    alu_op = ALU_OR;
            KIND_SLT:   alu_op = ALU_SLT;
            KIND_SLTU:  alu_op = ALU_SLTU;
            KIND_ADDI: begin
                alu_src = SRC_IMM;
            end
            KIND_ANDI: begin
                alu_op  = ALU_AND;
                alu_src = SRC_IMM;
            end
            KIND_XORI: begin
                alu_op  = ALU_XOR;
                alu_src = SRC_IMM;
            end
            KIND_SLTIU: begin
                alu_op  = ALU_SLTU;
                alu_src = SRC_IMM;
            end
            KIND_SLLI: begin
                alu_op  = ALU_SLL;
                alu_src = SRC_IMM;
            end
            KIND_SRAI: begin
                alu_op  = ALU_SRA;
                alu_src = SRC_IMM;
            end
            KIND_ADDW:  word_op = 1'b1;  // result sign-extended from bit 31
            KIND_SLLW: begin
                alu_op  = ALU_SLL;
                word_op = 1'b1;
            end
            KIND_ADDIW, KIND_LW: begin
                alu_src = SRC_IMM;
                word_op = 1'b1;
            end
            KIND_LD, KIND_LBU, KIND_LH,
            KIND_SB, KIND_SH, KIND_SW, KIND_SD,
            KIND_LUI: alu_src = SRC_IMM;  // address = rs1 + imm, lui uses x0
            KIND_JAL, KIND_JALR: alu_src = SRC_PC_FOUR;
            KIND_AUIPC: alu_src = SRC_IMM_PC;
            KIND_BEQ:   alu_op = ALU_BEQ;
            KIND_BNE:   alu_op = ALU_BNE;
            KIND_BLT:   alu_op = ALU_BLT;
            KIND_BGE:   alu_op = ALU_BGE;
            KIND_BLTU:  alu_op = ALU_BLTU;
            KIND_BGEU:  alu_op = ALU_BGEU;
            default: ;
        endcase
    end

endmodule

// File: source/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rv_decode_pkg::*; (
    input  logic [INST_W-1:0] inst,
    input  imm_sel_e          imm_sel,
    output logic [XLEN-1:0]   imm
);

    logic sign;

    assign sign = inst[INST_W-1];

    always_comb begin
        case (imm_sel)
            IMM_I: begin
                imm = {{(XLEN-12){sign}}, inst[31:20]};
            end
            IMM_S: begin
                imm = {{(XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                imm = {{(XLEN-13){sign}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {{(XLEN-32){sign}}, inst[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{(XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            IMM_SHAMT: begin
                imm = {{(XLEN-6){1'b0}}, inst[25:20]};  // rv64 shift amount
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: source/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl import rv_decode_pkg::*; (
    input  inst_kind_e        kind,
    output logic              mem_read,
    output logic              mem_write,
    output logic              load_unsigned,
    output mem_size_e         mem_size,
    output logic [MASK_W-1:0] store_mask
);

    always_comb begin
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        load_unsigned = 1'b0;
        mem_size      = MEM_BYTE;
        case (kind)
            KIND_LW: begin
                mem_read = 1'b1;
                mem_size = MEM_WORD;
            end
            KIND_LD: begin
                mem_read = 1'b1;
                mem_size = MEM_DOUBLE;
            end
            KIND_LBU: begin
                mem_read      = 1'b1;
                load_unsigned = 1'b1;  // zero-fill upper bytes
            end
            KIND_LH: begin
                mem_read = 1'b1;
                mem_size = MEM_HALF;
            end
            KIND_SB: mem_write = 1'b1;
            KIND_SH: begin
                mem_write = 1'b1;
                mem_size  = MEM_HALF;
            end
            KIND_SW: begin
                mem_write = 1'b1;
                mem_size  = MEM_WORD;
            end
            KIND_SD: begin
                mem_write = 1'b1;
                mem_size  = MEM_DOUBLE;
            end
            default: ;
        endcase
    end

    // lanes from the access size, stores only
    always_comb begin
        store_mask = '0;
        if (mem_write) begin
            case (mem_size)
                MEM_BYTE:   store_mask = 8'h01;
                MEM_HALF:   store_mask = 8'h03;
                MEM_WORD:   store_mask = 8'h0f;
                MEM_DOUBLE: store_mask = 8'hff;
                default:    store_mask = '0;
            endcase
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  logic [INST_W-1:0]     inst,
    output logic                  dec_valid,
    output alu_op_e               alu_op,
    output alu_src_e              alu_src,
    output logic                  word_op,
    output logic [XLEN-1:0]       imm,
    output logic                  reg_wen,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    output logic                  branch,
    output logic                  jump,
    output logic                  jalr,
    output logic                  mem_read,
    output logic                  mem_write,
    output mem_size_e             mem_size,
    output logic                  load_unsigned,
    output logic [MASK_W-1:0]     store_mask,
    output logic                  illegal,
    output logic                  ebreak
);

    inst_kind_e        kind;
    imm_sel_e          imm_sel;
    logic              illegal_c;
    alu_op_e           alu_op_c;
    alu_src_e          alu_src_c;
    logic              word_op_c;
    logic [XLEN-1:0]   imm_c;
    logic              mem_read_c;
    logic              mem_write_c;
    logic              load_unsigned_c;
    mem_size_e         mem_size_c;
    logic [MASK_W-1:0] store_mask_c;
    logic              rd_used;
    logic              rs1_used;
    logic              rs2_used;
    logic              branch_c;
    logic              jump_c;
    logic              jalr_c;
    logic              live;

    op_class u_op_class (
        .inst    (inst),
        .kind    (kind),
        .imm_sel (imm_sel),
        .illegal (illegal_c)
    );

    alu_ctrl u_alu_ctrl (
        .kind    (kind),
        .alu_op  (alu_op_c),
        .alu_src (alu_src_c),
        .word_op (word_op_c)
    );

    imm_gen u_imm_gen (
        .inst    (inst),
        .imm_sel (imm_sel),
        .imm     (imm_c)
    );

    mem_ctrl u_mem_ctrl (
        .kind          (kind),
        .mem_read      (mem_read_c),
        .mem_write     (mem_write_c),
        .load_unsigned (load_unsigned_c),
        .mem_size      (mem_size_c),
        .store_mask    (store_mask_c)
    );

    // which register fields a kind reads or writes
    always_comb begin
        rd_used  = 1'b1;
        rs1_used = 1'b1;
        rs2_used = 1'b0;
        branch_c = 1'b0;
        jump_c   = 1'b0;
        jalr_c   = 1'b0;
        case (kind)
            KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_SLT, KIND_SLTU,
            KIND_ADDW, KIND_SLLW: rs2_used = 1'b1;
            KIND_SB, KIND_SH, KIND_SW, KIND_SD: begin
                rd_used  = 1'b0;
                rs2_used = 1'b1;  // store data
            end
            KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU: begin
                rd_used  = 1'b0;
                rs2_used = 1'b1;
                branch_c = 1'b1;
            end
            KIND_JAL: begin
                rs1_used = 1'b0;
                jump_c   = 1'b1;
            end
            KIND_JALR: begin
                jump_c = 1'b1;
                jalr_c = 1'b1;
            end
            KIND_LUI, KIND_AUIPC: rs1_used = 1'b0;
            default: ;
        endcase
    end

    assign live = inst_valid && (kind != KIND_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid  <= 1'b0;
            reg_wen    <= 1'b0;
            branch     <= 1'b0;
            jump       <= 1'b0;
            jalr       <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            store_mask <= '0;
            illegal    <= 1'b0;
            ebreak     <= 1'b0;
        end else begin
            dec_valid  <= inst_valid;
            reg_wen    <= live && rd_used;
            branch     <= live && branch_c;
            jump       <= live && jump_c;
            jalr       <= live && jalr_c;
            mem_read   <= live && mem_read_c;
            mem_write  <= live && mem_write_c;
            store_mask <= live ? store_mask_c : '0;
            illegal    <= inst_valid && illegal_c;
            ebreak     <= inst_valid && (inst == EBREAK_WORD);
        end
    end

    // datapath fields, zero for idle and unrecognised words
    always_ff @(posedge clk) begin
        if (live) begin
            alu_op        <= alu_op_c;
            alu_src       <= alu_src_c;
            word_op       <= word_op_c;
            imm           <= imm_c;
            rd_addr       <= rd_used ? inst[RD_LSB +: REG_ADDR_W] : '0;
            rs1_addr      <= rs1_used ? inst[RS1_LSB +: REG_ADDR_W] : '0;
            rs2_addr      <= rs2_used ? inst[RS2_LSB +: REG_ADDR_W] : '0;
            mem_size      <= mem_size_c;
            load_unsigned <= load_unsigned_c;
        end else begin
            alu_op        <= ALU_ADD;
            alu_src       <= SRC_REG;
            word_op       <= 1'b0;
            imm           <= '0;
            rd_addr       <= '0;
            rs1_addr      <= '0;
            rs2_addr      <= '0;
            mem_size      <= MEM_BYTE;
            load_unsigned <= 1'b0;
        end
    end

endmodule

// File: sim/decode_tb.sv
`timescale 1ns/1ps

module decode_tb import rv_decode_pkg::*; ();

    localparam int MAX_VEC  = 64;
    localparam int EXP_W    = 106;
    localparam int RESET_CY = 5;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid;
    logic [INST_W-1:0]     inst;
    logic                  dec_valid;
    alu_op_e               alu_op;
    alu_src_e              alu_src;
    logic                  word_op;
    logic [XLEN-1:0]       imm;
    logic                  reg_wen;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic                  branch;
    logic                  jump;
    logic                  jalr;
    logic                  mem_read;
    logic                  mem_write;
    mem_size_e             mem_size;
    logic                  load_unsigned;
    logic [7:0]            store_mask;
    logic                  illegal;
    logic                  ebreak;

    string             t_name [MAX_VEC];
    logic              t_valid [MAX_VEC];
    logic [INST_W-1:0] t_inst [MAX_VEC];
    logic [EXP_W-1:0]  t_exp [MAX_VEC];
    int                n_vec;
    int                n_pass;
    int                n_fail;
    int                cycles;
    int                limit;
    logic [EXP_W-1:0]  act_vec;

    // read-side fields of one vector line
    string             line;
    string             v_name;
    logic              v_valid;
    logic [INST_W-1:0] v_inst;
    logic              e_dv, e_word, e_wen, e_br, e_j, e_jr, e_mr, e_mw, e_lu, e_ill, e_eb;
    logic [3:0]        e_op;
    logic [1:0]        e_src;
    logic [1:0]        e_size;
    logic [XLEN-1:0]   e_imm;
    logic [4:0]        e_rd, e_rs1, e_rs2;
    logic [7:0]        e_mask;

    decode_stage u_decode_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .dec_valid     (dec_valid),
        .alu_op        (alu_op),
        .alu_src       (alu_src),
        .word_op       (word_op),
        .imm           (imm),
        .reg_wen       (reg_wen),
        .rd_addr       (rd_addr),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .branch        (branch),
        .jump          (jump),
        .jalr          (jalr),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .store_mask    (store_mask),
        .illegal       (illegal),
        .ebreak        (ebreak)
    );

    assign act_vec = {dec_valid, alu_op, alu_src, word_op, imm, reg_wen, rd_addr, rs1_addr,
                      rs2_addr, branch, jump, jalr, mem_read, mem_write, mem_size,
                      load_unsigned, store_mask, illegal, ebreak};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic load_vectors();
        int fd;
        int cnt;
        int r;
        fd = $fopen("sim/decode_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/decode_stim.txt");
            n_fail++;
            return;
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            r = $fgets(line, fd);
            if (r == 0 || line.len() == 0 || line.getc(0) == 8'h23) continue;
            cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          v_name, v_valid, v_inst, e_dv, e_op, e_src, e_word, e_imm, e_wen,
                          e_rd, e_rs1, e_rs2, e_br, e_j, e_jr, e_mr, e_mw, e_size, e_lu,
                          e_mask, e_ill, e_eb);
            if (cnt == 22) begin
                t_name[n_vec]  = v_name;
                t_valid[n_vec] = v_valid;
                t_inst[n_vec]  = v_inst;
                t_exp[n_vec]   = {e_dv, e_op, e_src, e_word, e_imm, e_wen, e_rd, e_rs1, e_rs2,
                                  e_br, e_j, e_jr, e_mr, e_mw, e_size, e_lu, e_mask, e_ill,
                                  e_eb};
                n_vec++;
            end else if (cnt > 0) begin
                $display("malformed vector line: %s", line);
                n_fail++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_vector(input int idx);
        if (act_vec !== t_exp[idx]) begin
            $display("Fail %s expected %h actual %h", t_name[idx], t_exp[idx], act_vec);
            n_fail++;
        end else begin
            $display("ok   %s", t_name[idx]);
            n_pass++;
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        n_vec      = 0;
        n_pass     = 0;
        n_fail     = 0;
        cycles     = 0;
        limit      = 0;
        load_vectors();
        limit = RESET_CY + 2 * n_vec + 20;
        repeat (RESET_CY) @(posedge clk);
        @(negedge clk);
        // control outputs must be cleared while held in reset
        if ({dec_valid, reg_wen, branch, jump, jalr, mem_read, mem_write, store_mask,
             illegal, ebreak} !== '0) begin
            $display("Fail reset expected 0 actual %b", {dec_valid, reg_wen, branch, jump,
                     jalr, mem_read, mem_write, store_mask, illegal, ebreak});
            n_fail++;
        end else begin
            $display("ok   reset");
            n_pass++;
        end
        rst_n = 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            @(negedge clk);
            if (i > 0) check_vector(i - 1);  // one-deep pending result
            inst_valid = t_valid[i];
            inst       = t_inst[i];
        end
        @(negedge clk);
        if (n_vec > 0) check_vector(n_vec - 1);
        inst_valid = 1'b0;
        if (n_vec == 0) begin
            $display("no vectors were read");
            n_fail++;
        end
        $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/decode_stim.txt
# name valid inst | dec_valid alu_op alu_src word_op imm reg_wen rd rs1 rs2 branch jump jalr
# mem_read mem_write mem_size load_unsigned store_mask illegal ebreak (all hex)
add   1 003100B3 1 0 0 0 0000000000000003 1 1 2 3 0 0 0 0 0 0 0 00 0 0
sub   1 403100B3 1 1 0 0 0000000000000403 1 1 2 3 0 0 0 0 0 0 0 00 0 0
and   1 003170B3 1 2 0 0 0000000000000003 1 1 2 3 0 0 0 0 0 0 0 00 0 0
or    1 003160B3 1 3 0 0 0000000000000003 1 1 2 3 0 0 0 0 0 0 0 00 0 0
slt   1 003120B3 1 5 0 0 0000000000000003 1 1 2 3 0 0 0 0 0 0 0 00 0 0
sltu  1 003130B3 1 6 0 0 0000000000000003 1 1 2 3 0 0 0 0 0 0 0 00 0 0
addi  1 FFF10093 1 0 1 0 FFFFFFFFFFFFFFFF 1 1 2 0 0 0 0 0 0 0 0 00 0 0
andi  1 0F017093 1 2 1 0 00000000000000F0 1 1 2 0 0 0 0 0 0 0 0 00 0 0
xori  1 80034293 1 4 1 0 FFFFFFFFFFFFF800 1 5 6 0 0 0 0 0 0 0 0 00 0 0
sltiu 1 00513093 1 6 1 0 0000000000000005 1 1 2 0 0 0 0 0 0 0 0 00 0 0
slli  1 02111093 1 7 1 0 0000000000000021 1 1 2 0 0 0 0 0 0 0 0 00 0 0
srai  1 43F15093 1 8 1 0 000000000000003F 1 1 2 0 0 0 0 0 0 0 0 00 0 0
addw  1 003100BB 1 0 0 1 0000000000000003 1 1 2 3 0 0 0 0 0 0 0 00 0 0
sllw  1 003110BB 1 7 0 1 0000000000000003 1 1 2 3 0 0 0 0 0 0 0 00 0 0
addiw 1 FF81009B 1 0 1 1 FFFFFFFFFFFFFFF8 1 1 2 0 0 0 0 0 0 0 0 00 0 0
idle1 0 003100B3 0 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0 0 00 0 0
lw    1 01012083 1 0 1 1 0000000000000010 1 1 2 0 0 0 0 1 0 2 0 00 0 0
ld    1 FFC13203 1 0 1 0 FFFFFFFFFFFFFFFC 1 4 2 0 0 0 0 1 0 3 0 00 0 0
lbu   1 00014083 1 0 1 0 0000000000000000 1 1 2 0 0 0 0 1 0 0 1 00 0 0
lh    1 00211083 1 0 1 0 0000000000000002 1 1 2 0 0 0 0 1 0 1 0 00 0 0
sb    1 00310423 1 0 1 0 0000000000000008 0 0 2 3 0 0 0 0 1 0 0 01 0 0
sh    1 FE311F23 1 0 1 0 FFFFFFFFFFFFFFFE 0 0 2 3 0 0 0 0 1 1 0 03 0 0
sw    1 06312223 1 0 1 0 0000000000000064 0 0 2 3 0 0 0 0 1 2 0 0F 0 0
sd    1 00313023 1 0 1 0 0000000000000000 0 0 2 3 0 0 0 0 1 3 0 FF 0 0
beq   1 00310863 1 9 0 0 0000000000000010 0 0 2 3 1 0 0 0 0 0 0 00 0 0
bne   1 FE311EE3 1 A 0 0 FFFFFFFFFFFFFFFC 0 0 2 3 1 0 0 0 0 0 0 00 0 0
blt   1 003140E3 1 B 0 0 0000000000000800 0 0 2 3 1 0 0 0 0 0 0 00 0 0
bge   1 02315063 1 C 0 0 0000000000000020 0 0 2 3 1 0 0 0 0 0 0 00 0 0
bltu  1 00316463 1 D 0 0 0000000000000008 0 0 2 3 1 0 0 0 0 0 0 00 0 0
bgeu  1 80317063 1 E 0 0 FFFFFFFFFFFFF000 0 0 2 3 1 0 0 0 0 0 0 00 0 0
jal   1 001000EF 1 0 3 0 0000000000000800 1 1 0 0 0 1 0 0 0 0 0 00 0 0
jal_b 1 FFFFF06F 1 0 3 0 FFFFFFFFFFFFFFFE 1 0 0 0 0 1 0 0 0 0 0 00 0 0
jalr  1 00C100E7 1 0 3 0 000000000000000C 1 1 2 0 0 1 1 0 0 0 0 00 0 0
lui   1 123453B7 1 0 1 0 0000000012345000 1 7 0 0 0 0 0 0 0 0 0 00 0 0
auipc 1 FFFFF097 1 0 2 0 FFFFFFFFFFFFF000 1 1 0 0 0 0 0 0 0 0 0 00 0 0
fence 1 0000000F 1 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0 0 00 1 0
slti  1 00512093 1 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0 0 00 1 0
mul   1 023100B3 1 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0 0 00 1 0
mulw  1 023100BB 1 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0 0 00 1 0
remu  1 023170B3 1 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0 0 00 1 0
ecall 1 00000073 1 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0 0 00 1 0
ebrk  1 00100073 1 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0 0 00 0 1
idle2 0 00313023 0 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0 0 00 0 0
add2  1 003100B3 1 0 0 0 0000000000000003 1 1 2 3 0 0 0 0 0 0 0 00 0 0

// File: src.f
source/rv_decode_pkg.sv
source/op_class.sv
source/alu_ctrl.sv
source/imm_gen.sv
source/mem_ctrl.sv
source/decode_stage.sv
sim/decode_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module decode_tb -o decode_sim \
    && ./obj_dir/decode_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
